/* all.f */
+incdir+rtl
rtl/rv_exec_pkg.sv
rtl/rv_exec_if.sv
rtl/rv_pipe_reg.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_result.sv
rtl/rv_exec_top.sv
dv/tb_rv_exec.sv

/* dv/rv_exec_testdata.txt */
# name pc insn ra_data rb_data, then expected rd_we rd rd_data jump target illegal (all hex)
# rd and rd_data are checked only when rd_we is 1, target only when jump is 1
add      00000100 002082b3 12345678 00001111 1 05 12346789 0 00000000 0
sub      00000104 402082b3 00000005 00000007 1 05 fffffffe 0 00000000 0
sll      00000108 002092b3 00000003 00000024 1 05 00000030 0 00000000 0
slt      0000010c 0020a2b3 ffffffff 00000001 1 05 00000001 0 00000000 0
sltu     00000110 0020b2b3 ffffffff 00000001 1 05 00000000 0 00000000 0
xor      00000114 0020c2b3 f0f0f0f0 ff00ff00 1 05 0ff00ff0 0 00000000 0
srl      00000118 0020d2b3 80000000 00000004 1 05 08000000 0 00000000 0
sra      0000011c 4020d2b3 80000000 00000004 1 05 f8000000 0 00000000 0
addi     00000120 fff08293 00000010 00000000 1 05 0000000f 0 00000000 0
slti     00000124 0010a293 ffffffff 00000000 1 05 00000001 0 00000000 0
sltiu    00000128 fff0b293 00000005 00000000 1 05 00000001 0 00000000 0
xori     0000012c 8000c293 0000000f 00000000 1 05 fffff80f 0 00000000 0
ori      00000130 0f00e293 00000300 00000000 1 05 000003f0 0 00000000 0
andi     00000134 ff00f293 1234567f 00000000 1 05 12345670 0 00000000 0
slli     00000138 00809293 000000ab 00000000 1 05 0000ab00 0 00000000 0
srai     0000013c 4040d293 80000000 00000000 1 05 f8000000 0 00000000 0
lui      00000140 123452b7 00000000 00000000 1 05 12345000 0 00000000 0
auipc    00001000 00001297 00000000 00000000 1 05 00002000 0 00000000 0
jal_fwd  00000100 010000ef 00000000 00000000 1 01 00000104 1 00000110 0
jal_back 00000200 ffdff0ef 00000000 00000000 1 01 00000204 1 000001fc 0
jalr     00000300 005080e7 00001000 00000000 1 01 00000304 1 00001004 0
beq_t    00000400 00208463 00000005 00000005 0 00 00000000 1 00000408 0
bne_nt   00000400 00209463 00000005 00000005 0 00 00000000 0 00000000 0
blt_t    00000400 0020c463 ffffffff 00000001 0 00 00000000 1 00000408 0
bge_nt   00000400 0020d463 ffffffff 00000001 0 00 00000000 0 00000000 0
bltu_nt  00000400 0020e463 ffffffff 00000001 0 00 00000000 0 00000000 0
bgeu_t   00000400 0020f463 ffffffff 00000001 0 00 00000000 1 00000408 0
bne_back 00000500 fe209ce3 00000001 00000002 0 00 00000000 1 000004f8 0
load     00000600 0000a283 00000000 00000000 0 00 00000000 0 00000000 1
store    00000604 0020a023 00000000 00000000 0 00 00000000 0 00000000 1
unknown  00000608 000002ff 00000000 00000000 0 00 00000000 0 00000000 1
add_f7   0000060c 022082b3 00000001 00000002 0 00 00000000 0 00000000 1
addi_x0  00000610 00108013 00000001 00000000 0 00 00000000 0 00000000 0

/* dv/tb_rv_exec.sv */
// Self-checking testbench for rv_exec_top; run from the project root so the vector file is found
`timescale 1ns/1ns
`default_nettype none

module tb_rv_exec import rv_exec_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 100;

    logic      clk_i;
    logic      reset_i;
    logic      in_valid_i;
    logic      in_ready_o;
    word_t     pc_i;
    word_t     insn_i;
    word_t     ra_data_i;
    word_t     rb_data_i;
    logic      out_valid_o;
    logic      out_ready_i;
    logic      rd_we_o;
    reg_addr_t rd_addr_o;
    word_t     rd_data_o;
    logic      jump_o;
    word_t     target_o;
    logic      illegal_o;

    // --------------------
    // Vector table
    string     v_name[$];
    word_t     v_pc[$];
    word_t     v_insn[$];
    word_t     v_ra[$];
    word_t     v_rb[$];
    logic      v_we[$];
    reg_addr_t v_rd[$];
    word_t     v_rdd[$];
    logic      v_jmp[$];
    word_t     v_tgt[$];
    logic      v_ill[$];

    int edge_count  = 0;
    int accept_edge = 0;                        // Edge that took the first vector
    int checked     = 0;

    rv_exec_top dut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .pc_i        (pc_i),
        .insn_i      (insn_i),
        .ra_data_i   (ra_data_i),
        .rb_data_i   (rb_data_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .rd_we_o     (rd_we_o),
        .rd_addr_o   (rd_addr_o),
        .rd_data_o   (rd_data_o),
        .jump_o      (jump_o),
        .target_o    (target_o),
        .illegal_o   (illegal_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        edge_count <= edge_count + 1;
    end

    // Output back-pressure held high until the first result is through
    initial begin
        void'($urandom(32'h3b8d7cbd));
        out_ready_i = 1'b1;
        forever begin
            @(posedge clk_i);
            #1;
            if (checked > 0) begin
                out_ready_i = ($urandom % 3) != 0;
            end
        end
    end

    // --------------------
    // Failure and compare helpers
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input string test, input string field,
                              input word_t exp, input word_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("FAIL %s %s: expected %h, actual %h",
                                        test, field, exp, act));
        end
    endtask

    task automatic check_reg(input string test, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("FAIL %s rd: expected %0d, actual %0d", test, exp, act));
        end
    endtask

    task automatic check_flag(input string test, input string field,
                              input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("FAIL %s %s: expected %b, actual %b",
                                        test, field, exp, act));
        end
    endtask

    // --------------------
    // Vector file reader
    task automatic load_vectors();
        int        fd;
        int        n;
        string     line;
        string     name;
        word_t     pc;
        word_t     insn;
        word_t     ra;
        word_t     rb;
        word_t     rdd;
        word_t     tgt;
        logic      we;
        logic      jmp;
        logic      ill;
        reg_addr_t rd;
        fd = $fopen("dv/rv_exec_testdata.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Could not open dv/rv_exec_testdata.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin     // Skip comments and blanks
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h",
                            name, pc, insn, ra, rb, we, rd, rdd, jmp, tgt, ill);
                if (n != 11) begin
                    stop_with_failure($sformatf("Malformed vector line: %s", line));
                end
                v_name.push_back(name);
                v_pc.push_back(pc);
                v_insn.push_back(insn);
                v_ra.push_back(ra);
                v_rb.push_back(rb);
                v_we.push_back(we);
                v_rd.push_back(rd);
                v_rdd.push_back(rdd);
                v_jmp.push_back(jmp);
                v_tgt.push_back(tgt);
                v_ill.push_back(ill);
            end
        end
        $fclose(fd);
        if (v_name.size() == 0) begin
            stop_with_failure("The vector file holds no vectors");
        end
    endtask

    // --------------------
    // Input driver and output checker
    task automatic drive_inputs();
        int   idx;
        int   waited;
        logic took;
        for (idx = 0; idx < v_name.size(); idx++) begin
            in_valid_i = 1'b1;
            pc_i       = v_pc[idx];
            insn_i     = v_insn[idx];
            ra_data_i  = v_ra[idx];
            rb_data_i  = v_rb[idx];
            waited     = 0;
            took       = 1'b0;
            while (!took) begin
                @(negedge clk_i);                   // Ready is settled mid-cycle
                took = (in_ready_o === 1'b1);
                waited++;
                if (took && idx == 0) begin
                    accept_edge = edge_count + 1;
                end
                if (!took && waited > TIMEOUT_CYCLES) begin
                    stop_with_failure("Timed out waiting for in_ready_o to accept a vector");
                end
                @(posedge clk_i);
                #1;
            end
        end
        in_valid_i = 1'b0;
    endtask

    task automatic check_outputs();
        int    idx;
        int    waited;
        logic  took;
        string nm;
        for (idx = 0; idx < v_name.size(); idx++) begin
            nm     = v_name[idx];
            waited = 0;
            took   = 1'b0;
            while (!took) begin
                @(negedge clk_i);
                took = (out_valid_o === 1'b1) && (out_ready_i === 1'b1);
                waited++;
                if (!took && waited > TIMEOUT_CYCLES) begin
                    stop_with_failure($sformatf("Timed out waiting for out_valid_o for %s", nm));
                end
            end
            if (idx == 0 && edge_count != accept_edge + 2) begin    // Three cycles through
                stop_with_failure($sformatf("FAIL %s latency: expected edge %0d, actual %0d",
                                            nm, accept_edge + 2, edge_count));
            end
            check_flag(nm, "rd_we", v_we[idx], rd_we_o);
            check_flag(nm, "jump", v_jmp[idx], jump_o);
            check_flag(nm, "illegal", v_ill[idx], illegal_o);
            if (v_we[idx]) begin
                check_reg(nm, v_rd[idx], rd_addr_o);
                check_word(nm, "rd_data", v_rdd[idx], rd_data_o);
            end
            if (v_jmp[idx]) begin
                check_word(nm, "target", v_tgt[idx], target_o);
            end
            checked++;
        end
    endtask

    // Pipeline holds at most three items, so it is empty well within four cycles
    task automatic check_no_extra_output();
        int cycles;
        for (cycles = 0; cycles < 4; cycles++) begin
            @(negedge clk_i);
            if (out_valid_o !== 1'b0) begin
                stop_with_failure("An extra result came out after the last vector");
            end
        end
    endtask

    initial begin
        reset_i    = 1'b1;
        in_valid_i = 1'b0;
        pc_i       = '0;
        insn_i     = '0;
        ra_data_i  = '0;
        rb_data_i  = '0;
        load_vectors();
        repeat (2) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        fork
            drive_inputs();
            check_outputs();
        join
        check_no_extra_output();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/rv_decode.sv */
// Decode stage: splits the instruction, builds immediates and picks ALU/CMP work for execute
`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_macros.svh"

module rv_decode import rv_exec_pkg::*; (
    input  wire logic clk_i,
    input  wire logic reset_i,
    input  wire logic in_valid_i,
    output logic      in_ready_o,
    input  in_pl_t    in_pl_i,
    dec_bus_if.src    dec_o
);

    // --------------------
    // Instruction fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    logic       f7_base;
    logic       f7_alt;

    assign opcode  = in_pl_i.insn[6:0];
    assign rd      = in_pl_i.insn[11:7];
    assign funct3  = in_pl_i.insn[14:12];
    assign funct7  = in_pl_i.insn[31:25];
    assign f7_base = (funct7 == `RV_F7_BASE);
    assign f7_alt  = (funct7 == `RV_F7_ALT);

    // --------------------
    // Immediates
    word_t imm_i;
    word_t imm_sh;
    word_t imm_u;
    word_t imm_b;
    word_t imm_j;

    assign imm_i  = {{20{in_pl_i.insn[31]}}, in_pl_i.insn[31:20]};
    assign imm_sh = {27'b0, in_pl_i.insn[24:20]};     // Shift amount only
    assign imm_u  = {in_pl_i.insn[31:12], 12'b0};
    assign imm_b  = {{20{in_pl_i.insn[31]}}, in_pl_i.insn[7], in_pl_i.insn[30:25],
                     in_pl_i.insn[11:8], 1'b0};
    assign imm_j  = {{12{in_pl_i.insn[31]}}, in_pl_i.insn[19:12], in_pl_i.insn[20],
                     in_pl_i.insn[30:21], 1'b0};

    // --------------------
    // Operation decode
    dec_pl_t dec_d;
    dec_pl_t dec_q;

    always_comb begin
        dec_d.alu_op    = ALU_NOP;
        dec_d.alu_a     = in_pl_i.ra_data;
        dec_d.alu_b     = in_pl_i.rb_data;
        dec_d.cmp_op    = CMP_NOP;
        dec_d.cmp_a     = in_pl_i.ra_data;
        dec_d.cmp_b     = in_pl_i.rb_data;
        dec_d.pc        = in_pl_i.pc;
        dec_d.imm       = imm_i;
        dec_d.wb_sel    = WB_ALU;
        dec_d.jump_kind = JMP_NONE;
        dec_d.rd        = rd;
        dec_d.rd_we     = 1'b1;
        dec_d.illegal   = 1'b0;

        case (opcode)
            `RV_OP_IMM: begin
                dec_d.alu_b = imm_i;
                case (funct3)
                    `RV_F3_ADD: dec_d.alu_op = ALU_ADD;
                    `RV_F3_SLL: begin
                        dec_d.alu_op  = ALU_SLL;
                        dec_d.alu_b   = imm_sh;
                        dec_d.illegal = !f7_base;
                    end
                    `RV_F3_SLT: begin
                        dec_d.cmp_op = CMP_LT;
                        dec_d.cmp_b  = imm_i;
                        dec_d.wb_sel = WB_CMP;
                    end
                    `RV_F3_SLTU: begin
                        dec_d.cmp_op = CMP_LTU;
                        dec_d.cmp_b  = imm_i;         // Sign-extended, then unsigned compare
                        dec_d.wb_sel = WB_CMP;
                    end
                    `RV_F3_XOR: dec_d.alu_op = ALU_XOR;
                    `RV_F3_SR: begin
                        dec_d.alu_op  = f7_alt ? ALU_SRA : ALU_SRL;
                        dec_d.alu_b   = imm_sh;
                        dec_d.illegal = !(f7_base || f7_alt);
                    end
                    `RV_F3_OR:  dec_d.alu_op = ALU_OR;
                    default:    dec_d.alu_op = ALU_AND;
                endcase
            end
            `RV_OP_REG: begin
                // Only ADD/SUB and SRL/SRA have an alternate funct7
                dec_d.illegal = !(f7_base ||
                                  (f7_alt && (funct3 == `RV_F3_ADD || funct3 == `RV_F3_SR)));
                case (funct3)
                    `RV_F3_ADD: dec_d.alu_op = f7_alt ? ALU_SUB : ALU_ADD;
                    `RV_F3_SLL: dec_d.alu_op = ALU_SLL;
                    `RV_F3_SLT: begin
                        dec_d.cmp_op = CMP_LT;
                        dec_d.wb_sel = WB_CMP;
                    end
                    `RV_F3_SLTU: begin
                        dec_d.cmp_op = CMP_LTU;
                        dec_d.wb_sel = WB_CMP;
                    end
                    `RV_F3_XOR: dec_d.alu_op = ALU_XOR;
                    `RV_F3_SR:  dec_d.alu_op = f7_alt ? ALU_SRA : ALU_SRL;
                    `RV_F3_OR:  dec_d.alu_op = ALU_OR;
                    default:    dec_d.alu_op = ALU_AND;
                endcase
            end
            `RV_OP_LUI: begin
                dec_d.imm    = imm_u;
                dec_d.wb_sel = WB_IMM;
            end
            `RV_OP_AUIPC: begin
                dec_d.alu_op = ALU_ADD;
                dec_d.alu_a  = in_pl_i.pc;
                dec_d.alu_b  = imm_u;
                dec_d.imm    = imm_u;
            end
            `RV_OP_JAL: begin
                dec_d.alu_op    = ALU_ADD;
                dec_d.alu_a     = in_pl_i.pc;
                dec_d.alu_b     = imm_j;
                dec_d.imm       = imm_j;
                dec_d.wb_sel    = WB_LINK;
                dec_d.jump_kind = JMP_JUMP;
            end
            `RV_OP_JALR: begin
                dec_d.alu_op    = ALU_ADD;            // Bit 0 of the sum dropped in result
                dec_d.alu_b     = imm_i;
                dec_d.wb_sel    = WB_LINK;
                dec_d.jump_kind = JMP_JUMP;
                dec_d.illegal   = (funct3 != 3'b000);
            end
            `RV_OP_BRANCH: begin
                dec_d.alu_op    = ALU_ADD;            // Target PC + B immediate
                dec_d.alu_a     = in_pl_i.pc;
                dec_d.alu_b     = imm_b;
                dec_d.imm       = imm_b;
                dec_d.rd_we     = 1'b0;
                dec_d.jump_kind = JMP_BRANCH;
                case (funct3)
                    `RV_F3_BEQ:  dec_d.cmp_op = CMP_EQ;
                    `RV_F3_BNE:  dec_d.cmp_op = CMP_NE;
                    `RV_F3_BLT:  dec_d.cmp_op = CMP_LT;
                    `RV_F3_BGE:  dec_d.cmp_op = CMP_GE;
                    `RV_F3_BLTU: dec_d.cmp_op = CMP_LTU;
                    `RV_F3_BGEU: dec_d.cmp_op = CMP_GEU;
                    default:     dec_d.illegal = 1'b1;
                endcase
            end
            default: dec_d.illegal = 1'b1;           // Loads, stores and unknown opcodes
        endcase

        if (dec_d.illegal) begin
            dec_d.rd_we     = 1'b0;
            dec_d.jump_kind = JMP_NONE;
        end
        if (rd == '0) begin
            dec_d.rd_we = 1'b0;                       // x0 is never written
        end
    end

    rv_pipe_reg #(.payload_t(dec_pl_t)) u_dec_reg (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .valid_i   (in_valid_i),
        .payload_i (dec_d),
        .ready_o   (in_ready_o),
        .valid_o   (dec_o.valid),
        .payload_o (dec_q),
        .ready_i   (dec_o.ready)
    );

    assign dec_o.alu_op    = dec_q.alu_op;
    assign dec_o.alu_a     = dec_q.alu_a;
    assign dec_o.alu_b     = dec_q.alu_b;
    assign dec_o.cmp_op    = dec_q.cmp_op;
    assign dec_o.cmp_a     = dec_q.cmp_a;
    assign dec_o.cmp_b     = dec_q.cmp_b;
    assign dec_o.pc        = dec_q.pc;
    assign dec_o.imm       = dec_q.imm;
    assign dec_o.wb_sel    = dec_q.wb_sel;
    assign dec_o.jump_kind = dec_q.jump_kind;
    assign dec_o.rd        = dec_q.rd;
    assign dec_o.rd_we     = dec_q.rd_we;
    assign dec_o.illegal   = dec_q.illegal;

endmodule

`default_nettype wire

/* rtl/rv_exec_if.sv */
// Stage-to-stage buses of the slice; src side drives valid and data, dst side drives ready
`timescale 1ns/1ns
`default_nettype none

interface dec_bus_if import rv_exec_pkg::*; ();
    logic       valid;
    logic       ready;
    alu_op_e    alu_op;
    word_t      alu_a;
    word_t      alu_b;
    cmp_op_e    cmp_op;
    word_t      cmp_a;
    word_t      cmp_b;
    word_t      pc;
    word_t      imm;
    wb_sel_e    wb_sel;
    jump_kind_e jump_kind;
    reg_addr_t  rd;
    logic       rd_we;
    logic       illegal;

    modport src (output valid, alu_op, alu_a, alu_b, cmp_op, cmp_a, cmp_b, pc, imm,
                 wb_sel, jump_kind, rd, rd_we, illegal, input ready);
    modport dst (input valid, alu_op, alu_a, alu_b, cmp_op, cmp_a, cmp_b, pc, imm,
                 wb_sel, jump_kind, rd, rd_we, illegal, output ready);
endinterface

interface exe_bus_if import rv_exec_pkg::*; ();
    logic       valid;
    logic       ready;
    word_t      alu_res;
    logic       cmp_res;
    word_t      pc;
    word_t      imm;
    wb_sel_e    wb_sel;
    jump_kind_e jump_kind;
    reg_addr_t  rd;
    logic       rd_we;
    logic       illegal;

    modport src (output valid, alu_res, cmp_res, pc, imm, wb_sel, jump_kind, rd, rd_we,
                 illegal, input ready);
    modport dst (input valid, alu_res, cmp_res, pc, imm, wb_sel, jump_kind, rd, rd_we,
                 illegal, output ready);
endinterface

`default_nettype wire

/* rtl/rv_exec_macros.svh */
// Word and register widths plus RV32I opcode and funct encodings; include where decode needs them
`ifndef RV_EXEC_MACROS_SVH
`define RV_EXEC_MACROS_SVH

// --------------------
// Widths
`define RV_XLEN            32
`define RV_REG_AW          5

// --------------------
// Major opcodes
`define RV_OP_IMM          7'b0010011
`define RV_OP_REG          7'b0110011
`define RV_OP_LUI          7'b0110111
`define RV_OP_AUIPC        7'b0010111
`define RV_OP_BRANCH       7'b1100011
`define RV_OP_JAL          7'b1101111
`define RV_OP_JALR         7'b1100111

// --------------------
// funct3 for arithmetic, logic and shifts
`define RV_F3_ADD          3'b000
`define RV_F3_SLL          3'b001
`define RV_F3_SLT          3'b010
`define RV_F3_SLTU         3'b011
`define RV_F3_XOR          3'b100
`define RV_F3_SR           3'b101
`define RV_F3_OR           3'b110
`define RV_F3_AND          3'b111

// funct3 for conditional branches
`define RV_F3_BEQ          3'b000
`define RV_F3_BNE          3'b001
`define RV_F3_BLT          3'b100
`define RV_F3_BGE          3'b101
`define RV_F3_BLTU         3'b110
`define RV_F3_BGEU         3'b111

// funct7 variants
`define RV_F7_BASE         7'b0000000
`define RV_F7_ALT          7'b0100000

`endif

/* rtl/rv_exec_pkg.sv */
// Shared types of the execution slice; imported by stages, interfaces and the top level
`default_nettype none

`include "rv_exec_macros.svh"

package rv_exec_pkg;

    typedef logic [`RV_XLEN-1:0]   word_t;
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;

    // --------------------
    // Operation encodings
    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_XOR, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        CMP_NOP, CMP_EQ, CMP_NE, CMP_LT, CMP_LTU, CMP_GE, CMP_GEU
    } cmp_op_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_CMP, WB_LINK, WB_IMM
    } wb_sel_e;

    typedef enum logic [1:0] {
        JMP_NONE, JMP_BRANCH, JMP_JUMP
    } jump_kind_e;

    // --------------------
    // Stage payloads
    typedef struct packed {
        word_t pc;
        word_t insn;
        word_t ra_data;                 // rs1 value from register file
        word_t rb_data;                 // rs2 value from register file
    } in_pl_t;

    typedef struct packed {
        alu_op_e    alu_op;
        word_t      alu_a;
        word_t      alu_b;
        cmp_op_e    cmp_op;
        word_t      cmp_a;
        word_t      cmp_b;
        word_t      pc;
        word_t      imm;
        wb_sel_e    wb_sel;
        jump_kind_e jump_kind;
        reg_addr_t  rd;
        logic       rd_we;
        logic       illegal;
    } dec_pl_t;

    typedef struct packed {
        word_t      alu_res;
        logic       cmp_res;
        word_t      pc;
        word_t      imm;
        wb_sel_e    wb_sel;
        jump_kind_e jump_kind;
        reg_addr_t  rd;
        logic       rd_we;
        logic       illegal;
    } exe_pl_t;

    typedef struct packed {
        logic      rd_we;
        reg_addr_t rd;
        word_t     rd_data;
        logic      jump;
        word_t     target;
        logic      illegal;
    } res_pl_t;

endpackage

`default_nettype wire

/* rtl/rv_exec_top.sv */
// Top level of the RV32I execution slice; plain handshake ports around decode, execute, result
`timescale 1ns/1ns
`default_nettype none

module rv_exec_top import rv_exec_pkg::*; (
    input  wire logic clk_i,
    input  wire logic reset_i,
    input  wire logic in_valid_i,
    output logic      in_ready_o,
    input  word_t     pc_i,
    input  word_t     insn_i,
    input  word_t     ra_data_i,
    input  word_t     rb_data_i,
    output logic      out_valid_o,
    input  wire logic out_ready_i,
    output logic      rd_we_o,
    output reg_addr_t rd_addr_o,
    output word_t     rd_data_o,
    output logic      jump_o,
    output word_t     target_o,
    output logic      illegal_o
);

    in_pl_t  in_pl;
    res_pl_t res;

    dec_bus_if dec_bus ();
    exe_bus_if exe_bus ();

    assign in_pl = '{pc: pc_i, insn: insn_i, ra_data: ra_data_i, rb_data: rb_data_i};

    rv_decode u_decode (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .in_pl_i    (in_pl),
        .dec_o      (dec_bus.src)
    );

    rv_execute u_execute (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .dec_i   (dec_bus.dst),
        .exe_o   (exe_bus.src)
    );

    rv_result u_result (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .exe_i       (exe_bus.dst),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .res_o       (res)
    );

    assign rd_we_o   = res.rd_we;
    assign rd_addr_o = res.rd;
    assign rd_data_o = res.rd_data;
    assign jump_o    = res.jump;
    assign target_o  = res.target;
    assign illegal_o = res.illegal;

endmodule

`default_nettype wire

/* rtl/rv_execute.sv */
// Execute stage: ALU and comparator on the decoded operands, result registered toward write-back
`timescale 1ns/1ns
`default_nettype none

module rv_execute import rv_exec_pkg::*; (
    input  wire logic clk_i,
    input  wire logic reset_i,
    dec_bus_if.dst    dec_i,
    exe_bus_if.src    exe_o
);

    logic [4:0] shamt;
    exe_pl_t    exe_d;
    exe_pl_t    exe_q;

    assign shamt = dec_i.alu_b[4:0];

    // --------------------
    // ALU
    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD: exe_d.alu_res = dec_i.alu_a + dec_i.alu_b;
            ALU_SUB: exe_d.alu_res = dec_i.alu_a - dec_i.alu_b;
            ALU_SLL: exe_d.alu_res = dec_i.alu_a << shamt;
            ALU_SRL: exe_d.alu_res = dec_i.alu_a >> shamt;
            ALU_SRA: exe_d.alu_res = word_t'($signed(dec_i.alu_a) >>> shamt);
            ALU_XOR: exe_d.alu_res = dec_i.alu_a ^ dec_i.alu_b;
            ALU_OR:  exe_d.alu_res = dec_i.alu_a | dec_i.alu_b;
            ALU_AND: exe_d.alu_res = dec_i.alu_a & dec_i.alu_b;
            default: exe_d.alu_res = '0;
        endcase
    end

    // --------------------
    // Comparator
    always_comb begin
        case (dec_i.cmp_op)
            CMP_EQ:  exe_d.cmp_res = (dec_i.cmp_a == dec_i.cmp_b);
            CMP_NE:  exe_d.cmp_res = (dec_i.cmp_a != dec_i.cmp_b);
            CMP_LT:  exe_d.cmp_res = ($signed(dec_i.cmp_a) < $signed(dec_i.cmp_b));
            CMP_LTU: exe_d.cmp_res = (dec_i.cmp_a < dec_i.cmp_b);
            CMP_GE:  exe_d.cmp_res = ($signed(dec_i.cmp_a) >= $signed(dec_i.cmp_b));
            CMP_GEU: exe_d.cmp_res = (dec_i.cmp_a >= dec_i.cmp_b);
            default: exe_d.cmp_res = 1'b0;
        endcase
    end

    // Fields carried to write-back untouched
    assign exe_d.pc        = dec_i.pc;
    assign exe_d.imm       = dec_i.imm;
    assign exe_d.wb_sel    = dec_i.wb_sel;
    assign exe_d.jump_kind = dec_i.jump_kind;
    assign exe_d.rd        = dec_i.rd;
    assign exe_d.rd_we     = dec_i.rd_we;
    assign exe_d.illegal   = dec_i.illegal;

    rv_pipe_reg #(.payload_t(exe_pl_t)) u_exe_reg (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .valid_i   (dec_i.valid),
        .payload_i (exe_d),
        .ready_o   (dec_i.ready),
        .valid_o   (exe_o.valid),
        .payload_o (exe_q),
        .ready_i   (exe_o.ready)
    );

    assign exe_o.alu_res   = exe_q.alu_res;
    assign exe_o.cmp_res   = exe_q.cmp_res;
    assign exe_o.pc        = exe_q.pc;
    assign exe_o.imm       = exe_q.imm;
    assign exe_o.wb_sel    = exe_q.wb_sel;
    assign exe_o.jump_kind = exe_q.jump_kind;
    assign exe_o.rd        = exe_q.rd;
    assign exe_o.rd_we     = exe_q.rd_we;
    assign exe_o.illegal   = exe_q.illegal;

endmodule

`default_nettype wire

/* rtl/rv_pipe_reg.sv */
// One-entry valid/ready register closing each pipeline stage; payload type set per instance
`timescale 1ns/1ns
`default_nettype none

module rv_pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire logic clk_i,
    input  wire logic reset_i,
    input  wire logic valid_i,
    input  payload_t  payload_i,
    output logic      ready_o,
    output logic      valid_o,
    output payload_t  payload_o,
    input  wire logic ready_i
);

    logic     valid_q;
    payload_t payload_q;

    // Empty slot, or the held item leaves this cycle
    assign ready_o = !valid_q || ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            payload_q <= payload_i;     // Capture on transfer only
        end
    end

    assign valid_o   = valid_q;
    assign payload_o = payload_q;

endmodule

`default_nettype wire

/* rtl/rv_result.sv */
// Result stage: picks the register write-back value and forms the redirect, then registers it
`timescale 1ns/1ns
`default_nettype none

module rv_result import rv_exec_pkg::*; (
    input  wire logic clk_i,
    input  wire logic reset_i,
    exe_bus_if.dst    exe_i,
    output logic      out_valid_o,
    input  wire logic out_ready_i,
    output res_pl_t   res_o
);

    word_t   link;
    res_pl_t res_d;

    assign link = exe_i.pc + word_t'(4);         // Return address

    always_comb begin
        res_d.rd_we   = exe_i.rd_we;
        res_d.rd      = exe_i.rd;
        res_d.illegal = exe_i.illegal;

        case (exe_i.wb_sel)
            WB_ALU:  res_d.rd_data = exe_i.alu_res;
            WB_CMP:  res_d.rd_data = word_t'(exe_i.cmp_res);
            WB_LINK: res_d.rd_data = link;
            default: res_d.rd_data = exe_i.imm;
        endcase

        res_d.jump   = (exe_i.jump_kind == JMP_JUMP) ||
                       (exe_i.jump_kind == JMP_BRANCH && exe_i.cmp_res);
        res_d.target = exe_i.alu_res;
        if (exe_i.jump_kind == JMP_JUMP) begin
            res_d.target[0] = 1'b0;                   // JALR clears bit 0, JAL is even already
        end
    end

    rv_pipe_reg #(.payload_t(res_pl_t)) u_res_reg (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .valid_i   (exe_i.valid),
        .payload_i (res_d),
        .ready_o   (exe_i.ready),
        .valid_o   (out_valid_o),
        .payload_o (res_o),
        .ready_i   (out_ready_i)
    );

endmodule

`default_nettype wire
